// ==== verilog/dga_defs.svh ====
/*
 * ND120 decode gate array, clk2 side
 * Field widths and fixed control-store codes
 */
`ifndef DGA_DEFS_SVH
`define DGA_DEFS_SVH

// Control-store command field
`define DGA_CMD_W 5

// Control-store misc field
`define DGA_MIS_W 2

// Misc value shared by LDMISC, MEMRD fetch and device access
`define DGA_MIS_BOTH 2'b11

`endif

// ==== verilog/dga_pkg.sv ====
/*
 * ND120 decode gate array types
 * Command codes, decode terms and registered cycle state
 */
`include "dga_defs.svh"

package dga_pkg;

  // Named control-store commands
  // Any other code is a short-cycle candidate
  typedef enum logic [`DGA_CMD_W-1:0] {
    CMD_LDMISC = 5'h11, CMD_MEMRD  = 5'h12,
    CMD_FETCH0 = 5'h13, CMD_FETCH1 = 5'h14, CMD_FETCH2 = 5'h15,
    CMD_FETCH3 = 5'h16, CMD_FETCH4 = 5'h17,
    CMD_RDCYC0 = 5'h18, CMD_RDCYC1 = 5'h19, CMD_RDCYC2 = 5'h1C,
    CMD_WRCYC0 = 5'h1A, CMD_WRCYC1 = 5'h1B,
    CMD_WRPHYS = 5'h1D,
    CMD_RWCS   = 5'h1E,
    CMD_IORQ   = 5'h1F
  } dga_cmd_e;

  // Active-high memory-cycle decode terms
  typedef struct packed {
    logic fetch_d;
    logic dt_d;
    logic rt_d;
    logic form_d;
    logic mreq_d;
    logic write_d;
  } dga_mem_terms_t;

  // Control-cycle decode terms
  // dvacc_mem still needs the misc latch before it counts
  typedef struct packed {
    logic ldmisc_d;
    logic short_d;
    logic rwcs_d;
    logic iorq_d;
    logic dvacc_d;
    logic dvacc_mem;
  } dga_ctl_terms_t;

  // Registered state seen by the cache request logic
  typedef struct packed {
    logic mem_cycle;
    logic write;
    logic iorq;
  } dga_cycle_t;

endpackage

// ==== verilog/dga_cmd_decode.sv ====
/*
 * Command decoder
 * Turns cscomm, csmis and lcs_n into memory and control decode terms
 */
`timescale 1ns/1ps
`include "dga_defs.svh"

module dga_cmd_decode (
  input  logic [`DGA_CMD_W-1:0]  cscomm,
  input  logic [`DGA_MIS_W-1:0]  csmis,
  input  logic                   lcs_n,
  input  logic                   poni,
  output dga_pkg::dga_mem_terms_t mem_terms,
  output dga_pkg::dga_ctl_terms_t ctl_terms
);

  dga_pkg::dga_cmd_e cmd;
  logic              mis_both;

  assign cmd      = dga_pkg::dga_cmd_e'(cscomm);
  assign mis_both = (csmis == `DGA_MIS_BOTH);

  always_comb begin
    mem_terms = '0;
    ctl_terms = '0;
    // Nothing decodes while the control store is deselected
    if (lcs_n) begin
      case (cmd)
        dga_pkg::CMD_LDMISC: begin
          ctl_terms.ldmisc_d = mis_both;
          ctl_terms.short_d  = |csmis;
        end
        dga_pkg::CMD_MEMRD: begin
          // Misc field picks fetch, read or form variant
          mem_terms.rt_d    = mis_both | ~csmis[1];
          mem_terms.fetch_d = mis_both;
          mem_terms.dt_d    = ~csmis[1];
          mem_terms.form_d  = csmis[1];
          mem_terms.mreq_d  = 1'b1;
        end
        dga_pkg::CMD_FETCH0, dga_pkg::CMD_FETCH1, dga_pkg::CMD_FETCH2,
        dga_pkg::CMD_FETCH3, dga_pkg::CMD_FETCH4: begin
          mem_terms.rt_d    = 1'b1;
          mem_terms.fetch_d = 1'b1;
          mem_terms.form_d  = 1'b1;
          mem_terms.mreq_d  = 1'b1;
        end
        dga_pkg::CMD_RDCYC0, dga_pkg::CMD_RDCYC1, dga_pkg::CMD_RDCYC2: begin
          mem_terms.rt_d   = 1'b1;
          mem_terms.dt_d   = 1'b1;
          mem_terms.mreq_d = 1'b1;
          // 0x1C doubles as a device access
          ctl_terms.dvacc_mem = mis_both && (cmd == dga_pkg::CMD_RDCYC2);
        end
        dga_pkg::CMD_WRCYC0, dga_pkg::CMD_WRCYC1, dga_pkg::CMD_WRPHYS: begin
          mem_terms.dt_d    = 1'b1;
          mem_terms.mreq_d  = 1'b1;
          mem_terms.write_d = 1'b1;
          ctl_terms.dvacc_mem = mis_both && (cmd == dga_pkg::CMD_WRPHYS);
        end
        dga_pkg::CMD_RWCS: ctl_terms.rwcs_d = (csmis == 2'b01);
        dga_pkg::CMD_IORQ: ctl_terms.iorq_d = csmis[1];
        default: begin
          // Short-cycle group among the unnamed codes
          casez (cscomm)
            5'b000??, 5'b011??: ctl_terms.short_d = 1'b1;
            5'b00100, 5'b10000: ctl_terms.short_d = 1'b1;
            5'b0011?:           ctl_terms.short_d = csmis[0];
            default:            ctl_terms.short_d = 1'b0;
          endcase
        end
      endcase
      ctl_terms.dvacc_d = ctl_terms.iorq_d | poni;
    end
  end

endmodule

// ==== verilog/dga_mem_cycle_regs.sv ====
/*
 * Memory-cycle register bank
 * Registers the memory decode terms with the gate array output polarities
 */
`timescale 1ns/1ps

module dga_mem_cycle_regs (
  input  logic                    clk2,
  input  logic                    rst_n,
  input  dga_pkg::dga_mem_terms_t mem_terms,
  output logic                    fetch,
  output logic                    form_n,
  output logic                    mreq,
  output logic                    write,
  output logic                    dt_n,
  output logic                    rt_n,
  output logic [1:0]              mem_state
);

  dga_pkg::dga_mem_terms_t mem_q;

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_terms;
    end
  end

  // Output polarities of the gate array pins
  assign fetch  = mem_q.fetch_d;
  assign form_n = ~mem_q.form_d;
  assign mreq   = ~mem_q.mreq_d;
  assign write  = mem_q.write_d;
  assign dt_n   = ~mem_q.dt_d;
  assign rt_n   = ~mem_q.rt_d;

  // Read timing flop doubles as the memory-cycle state
  assign mem_state = {mem_q.rt_d, mem_q.write_d};

  // Every write cycle also drives data transfer
  a_write_has_dt: assert property (
    @(posedge clk2) disable iff (!rst_n) write |-> !dt_n
  );

endmodule

// ==== verilog/dga_ctl_regs.sv ====
/*
 * Control-cycle registers
 * Short, rwcs and iorq strobes, misc latch from idbi2 and device access
 */
`timescale 1ns/1ps

module dga_ctl_regs (
  input  logic                    clk2,
  input  logic                    rst_n,
  input  dga_pkg::dga_ctl_terms_t ctl_terms,
  input  logic                    idbi2,
  output logic                    short_n,
  output logic                    rwcs_n,
  output logic                    iorq_n,
  output logic                    dvacc_n,
  output logic                    iorq_active
);

  logic misc_q;
  logic dvacc;

  // Memory-type device access is masked while the misc bit is set
  assign dvacc = ctl_terms.dvacc_d | (ctl_terms.dvacc_mem & ~misc_q);

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      short_n <= 1'b1;
      rwcs_n  <= 1'b1;
      iorq_n  <= 1'b1;
      dvacc_n <= 1'b1;
    end else begin
      short_n <= ~ctl_terms.short_d;
      rwcs_n  <= ~ctl_terms.rwcs_d;
      iorq_n  <= ~ctl_terms.iorq_d;
      dvacc_n <= ~dvacc;
    end
  end

  // Misc latch loads with the LDMISC command and holds otherwise
  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      misc_q <= 1'b0;
    end else if (ctl_terms.ldmisc_d) begin
      misc_q <= idbi2;
    end
  end

  assign iorq_active = ~iorq_n;

  // Control store and IO cycles exclude each other
  a_rwcs_iorq_excl: assert property (
    @(posedge clk2) disable iff (!rst_n) !(!rwcs_n && !iorq_n)
  );

  a_short_no_iorq: assert property (
    @(posedge clk2) disable iff (!rst_n) !short_n |-> iorq_n
  );

endmodule

// ==== verilog/dga_cache_req.sv ====
/*
 * Cache request and stop logic
 * Combines registered cycle state with live bus inputs
 */
`timescale 1ns/1ps

module dga_cache_req (
  input  dga_pkg::dga_cycle_t cycle,
  input  logic                hit_n,
  input  logic                brk_n,
  input  logic                eorf_n,
  input  logic                lshadow,
  input  logic                dap_n,
  output logic                ecreq,
  output logic                stoc_n,
  output logic                estof_n
);

  logic bus_ready;

  // No break, no shadow access and the bus already granted
  assign bus_ready = brk_n & ~lshadow & ~eorf_n;

  assign ecreq = (cycle.mem_cycle & hit_n & bus_ready) |
                 (cycle.write & bus_ready) |
                 (cycle.iorq & ~eorf_n);

  assign stoc_n = ~((cycle.mem_cycle & ~lshadow) | (cycle.iorq & ~dap_n));

  // Plain AND gate that stays low while idle
  assign estof_n = lshadow & cycle.mem_cycle;

endmodule

// ==== verilog/dga_decode.sv ====
/*
 * ND120 decode gate array, clk2 side
 * Command decode, memory and control strobes, cache request logic
 */
`timescale 1ns/1ps
`include "dga_defs.svh"

module dga_decode (
  input  logic                  clk2,
  input  logic                  rst_n,
  input  logic [`DGA_CMD_W-1:0] cscomm,
  input  logic [`DGA_MIS_W-1:0] csmis,
  input  logic                  lcs_n,
  input  logic                  poni,
  input  logic                  idbi2,
  input  logic                  hit_n,
  input  logic                  brk_n,
  input  logic                  eorf_n,
  input  logic                  lshadow,
  input  logic                  dap_n,
  output logic                  fetch,
  output logic                  form_n,
  output logic                  mreq,
  output logic                  write,
  output logic                  dt_n,
  output logic                  rt_n,
  output logic                  short_n,
  output logic                  rwcs_n,
  output logic                  iorq_n,
  output logic                  dvacc_n,
  output logic                  ecreq,
  output logic                  stoc_n,
  output logic                  estof_n
);

  dga_pkg::dga_mem_terms_t mem_terms;
  dga_pkg::dga_ctl_terms_t ctl_terms;
  dga_pkg::dga_cycle_t     cycle;
  logic [1:0]              mem_state;
  logic                    iorq_active;

  dga_cmd_decode u_cmd_decode (
    .cscomm    (cscomm),
    .csmis     (csmis),
    .lcs_n     (lcs_n),
    .poni      (poni),
    .mem_terms (mem_terms),
    .ctl_terms (ctl_terms)
  );

  dga_mem_cycle_regs u_mem_regs (
    .clk2      (clk2),
    .rst_n     (rst_n),
    .mem_terms (mem_terms),
    .fetch     (fetch),
    .form_n    (form_n),
    .mreq      (mreq),
    .write     (write),
    .dt_n      (dt_n),
    .rt_n      (rt_n),
    .mem_state (mem_state)
  );

  dga_ctl_regs u_ctl_regs (
    .clk2        (clk2),
    .rst_n       (rst_n),
    .ctl_terms   (ctl_terms),
    .idbi2       (idbi2),
    .short_n     (short_n),
    .rwcs_n      (rwcs_n),
    .iorq_n      (iorq_n),
    .dvacc_n     (dvacc_n),
    .iorq_active (iorq_active)
  );

  // mem_cycle and write come from the memory bank and iorq from the control bank
  assign cycle = {mem_state, iorq_active};

  dga_cache_req u_cache_req (
    .cycle   (cycle),
    .hit_n   (hit_n),
    .brk_n   (brk_n),
    .eorf_n  (eorf_n),
    .lshadow (lshadow),
    .dap_n   (dap_n),
    .ecreq   (ecreq),
    .stoc_n  (stoc_n),
    .estof_n (estof_n)
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
/*
 * Testbench clock and reset source
 * 100 ns clk2 and an active-low reset held for 16 cycles
 */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 16
) (
  output logic clk2,
  output logic rst_n
);

  initial begin
    clk2  = 1'b0;
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk2);
    rst_n <= 1'b1;
  end

  always #(PERIOD / 2) clk2 = ~clk2;

endmodule

// ==== tb/dga_decode_checker.sv ====
/*
 * Output checker for the decode gate array
 * Compares registered strobes and recomputes the cache request outputs
 */
`timescale 1ns/1ps

module dga_decode_checker (
  input  logic       clk2,
  input  logic [9:0] regs,
  input  logic [9:0] exp_regs,
  input  logic       hit_n,
  input  logic       brk_n,
  input  logic       eorf_n,
  input  logic       lshadow,
  input  logic       dap_n,
  input  logic       ecreq,
  input  logic       stoc_n,
  input  logic       estof_n,
  output int         errors
);

  // Registered output word names from the msb down
  string names [10] = '{"fetch", "form_n", "mreq", "write", "dt_n",
                        "rt_n", "short_n", "rwcs_n", "iorq_n", "dvacc_n"};
  logic armed = 1'b0;
  logic mem_cycle;
  logic wr;
  logic iorq;
  logic ready;
  int   idx;

  initial errors = 0;

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  always @(posedge clk2) armed <= 1'b1;

  // Registered and driven values are settled at the falling edge
  always @(negedge clk2) begin
    if (armed) begin
      for (idx = 0; idx < 10; idx++) begin
        compare_bit(names[idx], exp_regs[9 - idx], regs[9 - idx]);
      end
      mem_cycle = ~regs[4];
      wr        = regs[6];
      iorq      = ~regs[1];
      ready     = brk_n & ~lshadow & ~eorf_n;
      compare_bit("ecreq", (mem_cycle & hit_n & ready) | (wr & ready) | (iorq & ~eorf_n),
                  ecreq);
      compare_bit("stoc_n", ~((mem_cycle & ~lshadow) | (iorq & ~dap_n)), stoc_n);
      compare_bit("estof_n", lshadow & mem_cycle, estof_n);
      if (!regs[2] && !regs[1]) begin
        errors++;
        $display("Error at %0d ns: rwcs_n and iorq_n are low at the same time", $time);
      end
    end
  end

endmodule

// ==== tb/tb_dga_decode.sv ====
/*
 * Testbench for the decode gate array clk2 side
 * Table of commands and bus inputs with expected strobes, one row per cycle
 */
`timescale 1ns/1ps
`include "dga_defs.svh"

module tb_dga_decode;

  typedef struct packed {
    logic [`DGA_CMD_W-1:0] cscomm;
    logic [`DGA_MIS_W-1:0] csmis;
    logic                  lcs_n;
    logic                  poni;
    logic                  idbi2;
    logic [4:0]            bus;
    logic [9:0]            exp_regs;
  } row_t;

  // fetch form_n mreq write dt_n rt_n short_n rwcs_n iorq_n dvacc_n
  localparam logic [9:0] IDLE_REGS = 10'b0110111111;

  logic clk2, rst_n;
  logic [`DGA_CMD_W-1:0] cscomm;
  logic [`DGA_MIS_W-1:0] csmis;
  logic lcs_n, poni, idbi2, hit_n, brk_n, eorf_n, lshadow, dap_n;
  logic fetch, form_n, mreq, write, dt_n, rt_n, short_n, rwcs_n, iorq_n, dvacc_n;
  logic ecreq, stoc_n, estof_n;
  logic [9:0] exp_regs;
  logic       model_misc;
  logic       table_ready;
  row_t       rows [$];
  int         errors;

  tb_clk_gen u_clk (.clk2(clk2), .rst_n(rst_n));

  dga_decode dut0 (.*);

  dga_decode_checker u_checker (
    .clk2 (clk2),
    .regs ({fetch, form_n, mreq, write, dt_n, rt_n, short_n, rwcs_n, iorq_n, dvacc_n}),
    .exp_regs (exp_regs), .hit_n (hit_n), .brk_n (brk_n), .eorf_n (eorf_n),
    .lshadow (lshadow), .dap_n (dap_n), .ecreq (ecreq), .stoc_n (stoc_n),
    .estof_n (estof_n), .errors (errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Strobe word expected one cycle after a command from the code groups
  function automatic logic [9:0] expected_regs(input logic [4:0] c, input logic [1:0] m,
                                               input logic sel, input logic pon,
                                               input logic latch);
    logic both, memc, fet, dt, form, mrq, wr, shrt, rwcs, iorq, dva;
    both = (m == 2'b11);
    memc = sel && ((c >= 5'h13 && c <= 5'h19) || c == 5'h1C || (c == 5'h12 && (both || !m[1])));
    fet  = sel && ((c >= 5'h13 && c <= 5'h17) || (c == 5'h12 && both));
    dt   = sel && ((c >= 5'h18 && c <= 5'h1D) || (c == 5'h12 && !m[1]));
    form = sel && ((c >= 5'h13 && c <= 5'h17) || (c == 5'h12 && m[1]));
    mrq  = sel && c >= 5'h12 && c <= 5'h1D;
    wr   = sel && (c == 5'h1A || c == 5'h1B || c == 5'h1D);
    rwcs = sel && c == 5'h1E && m == 2'b01;
    iorq = sel && c == 5'h1F && m[1];
    shrt = sel && (c <= 5'h04 || (c >= 5'h0C && c <= 5'h0F) || c == 5'h10 ||
                   ((c == 5'h06 || c == 5'h07) && m[0]) || (c == 5'h11 && m != 2'b00));
    dva  = iorq || (sel && pon) || (sel && (c == 5'h1C || c == 5'h1D) && both && !latch);
    return {fet, ~form, ~mrq, wr, ~dt, ~memc, ~shrt, ~rwcs, ~iorq, ~dva};
  endfunction

  task automatic add_row(input logic [4:0] c, input logic [1:0] m, input logic sel,
                         input logic pon, input logic ib, input logic [4:0] bus);
    rows.push_back({c, m, sel, pon, ib, bus, expected_regs(c, m, sel, pon, model_misc)});
    // Misc bit follows idbi2 from the command after LDMISC
    if (sel && c == 5'h11 && m == `DGA_MIS_BOTH) model_misc = ib;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [4:0]  bus_idle;
    logic [4:0]  held_codes [3];
    int c, m, l, b, k;
    cscomm = '0;
    csmis = '0;
    lcs_n = 1'b0;
    poni = 1'b0;
    idbi2 = 1'b0;
    {hit_n, brk_n, eorf_n, lshadow, dap_n} = 5'b11101;
    exp_regs = IDLE_REGS;
    model_misc = 1'b0;
    table_ready = 1'b0;
    rnd = 32'h7b48365b;
    bus_idle = 5'b11101;
    held_codes = '{5'h13, 5'h1A, 5'h1F};
    for (k = 0; k < 3; k++) add_row(5'h00, 2'b00, 1'b0, 1'b0, 1'b0, bus_idle);
    // Misc latch masking the memory-type device access and then poni alone
    add_row(5'h11, 2'b11, 1'b1, 1'b0, 1'b1, bus_idle);
    add_row(5'h1C, 2'b11, 1'b1, 1'b0, 1'b0, bus_idle);
    add_row(5'h11, 2'b11, 1'b1, 1'b0, 1'b0, bus_idle);
    add_row(5'h1C, 2'b11, 1'b1, 1'b0, 1'b0, bus_idle);
    add_row(5'h1D, 2'b11, 1'b1, 1'b0, 1'b0, bus_idle);
    add_row(5'h08, 2'b00, 1'b1, 1'b1, 1'b0, bus_idle);
    // Fetch, write and IO cycles held while the bus inputs walk all patterns
    for (k = 0; k < 3; k++)
      for (b = 0; b < 32; b++) add_row(held_codes[k], 2'b10, 1'b1, 1'b0, 1'b0, b[4:0]);
    // Every code and misc value both selected and deselected with random bus inputs
    for (c = 0; c < 32; c++)
      for (m = 0; m < 4; m++)
        for (l = 0; l < 2; l++) begin
          rnd = xorshift32(rnd);
          add_row(c[4:0], m[1:0], l == 0, 1'b0, rnd[7], rnd[4:0]);
        end
    table_ready = 1'b1;
    wait (rst_n === 1'b1);
    for (k = 0; k < rows.size(); k++) begin
      @(posedge clk2);
      cscomm <= rows[k].cscomm;
      csmis <= rows[k].csmis;
      lcs_n <= rows[k].lcs_n;
      poni <= rows[k].poni;
      idbi2 <= rows[k].idbi2;
      {hit_n, brk_n, eorf_n, lshadow, dap_n} <= rows[k].bus;
      exp_regs <= (k == 0) ? IDLE_REGS : rows[k - 1].exp_regs;
    end
    @(posedge clk2);
    lcs_n <= 1'b0;
    exp_regs <= rows[rows.size() - 1].exp_regs;
    @(posedge clk2);
    exp_regs <= IDLE_REGS;
    @(negedge clk2);
    #1;
    $display("Checks done, %0d rows, %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready === 1'b1);
    #((rows.size() + 40) * 100);
    $display("Watchdog expired before the table finished");
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/dga_pkg.sv
verilog/dga_cmd_decode.sv
verilog/dga_mem_cycle_regs.sv
verilog/dga_ctl_regs.sv
verilog/dga_cache_req.sv
verilog/dga_decode.sv
tb/tb_clk_gen.sv
tb/dga_decode_checker.sv
tb/tb_dga_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dga_decode
RTL_TOP   ?= dga_decode
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= verilog/dga_pkg.sv verilog/dga_cmd_decode.sv verilog/dga_mem_cycle_regs.sv \
             verilog/dga_ctl_regs.sv verilog/dga_cache_req.sv verilog/dga_decode.sv

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall -Iverilog --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
